// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fmul
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+hw
hw/fmul_pkg.sv
hw/fmul_norm_if.sv
hw/fmul_booth.sv
hw/fmul_norm.sv
hw/fmul_round.sv
hw/fmul_exp.sv
hw/fmul_top.sv
testbench/fmul_checker.sv
testbench/tb_fmul.sv

// ==== hw/fmul_booth.sv ====
module fmul_booth (
    input  fmul_pkg::sig_t  sig_x,
    input  fmul_pkg::sig_t  sig_y,
    output fmul_pkg::prod_t prod
);
    import fmul_pkg::*;

    // Significand width and number of radix-4 digits
    // One extra digit covers the zero top bits of the unsigned multiplier
    localparam int SW   = $bits(sig_t);
    localparam int NDIG = SW / 2 + 1;

    // Multiplier with two zero bits on top and the implicit zero below
    logic [SW+2:0] y_ext;

    // Per-digit recoding: negative, magnitude one, magnitude two
    logic [NDIG-1:0] d_neg;
    logic [NDIG-1:0] d_one;
    logic [NDIG-1:0] d_two;

    // Shifted and sign-corrected partial products
    prod_t pp [NDIG];

    assign y_ext = {2'b00, sig_y, 1'b0};

    genvar gi;
    generate
        for (gi = 0; gi < NDIG; gi++) begin : g_dig
            logic [2:0] grp;
            logic [SW:0] mag;
            prod_t mag_w;

            // Overlapping triplet y[2i+1], y[2i], y[2i-1]
            assign grp = y_ext[2*gi+2 -: 3];

            // 100, 101, 110 are negative; 111 is zero
            assign d_neg[gi] = grp[2] & ~(grp[1] & grp[0]);
            // 001, 010, 101, 110 select one times x
            assign d_one[gi] = grp[1] ^ grp[0];
            // 011 and 100 select two times x
            assign d_two[gi] = (grp == 3'b011) | (grp == 3'b100);

            // Magnitude of the digit times x
            assign mag = d_two[gi] ? {sig_x, 1'b0} :
                         d_one[gi] ? {1'b0, sig_x}  : '0;

            // Zero-extend to product width before negation
            assign mag_w = prod_t'(mag);

            // Two's complement for negative digits, then weight by 4^i
            assign pp[gi] = (d_neg[gi] ? (~mag_w + prod_t'(1)) : mag_w) << (2 * gi);
        end
    endgenerate

    // Sum modulo 2^48 is exact since the unsigned product fits
    always_comb begin
        prod = '0;
        for (int i = 0; i < NDIG; i++) begin
            prod = prod + pp[i];
        end
    end

endmodule

// ==== hw/fmul_consts.svh ====
`ifndef FMUL_CONSTS_SVH
`define FMUL_CONSTS_SVH

// Binary32 field widths
`define FMUL_EXP_W 8
`define FMUL_FRC_W 23

// Exponent bias of binary32
`define FMUL_BIAS 127

// Canonical quiet NaN, every NaN result uses it
`define FMUL_QNAN 32'h7fc00000

// Rounding-mode codes, 5 to 7 fall back to nearest-even
`define FMUL_RM_RNE 3'd0
`define FMUL_RM_RTZ 3'd1
`define FMUL_RM_RDN 3'd2
`define FMUL_RM_RUP 3'd3
`define FMUL_RM_RMM 3'd4

`endif

// ==== hw/fmul_exp.sv ====
`include "fmul_consts.svh"

module fmul_exp (
    input  fmul_pkg::fp32_t fp_x,
    input  fmul_pkg::fp32_t fp_y,
    input  logic            norm_n,
    input  logic            norm_r,
    input  fmul_pkg::frc_t  frc_z,
    output fmul_pkg::sig_t  sig_x,
    output fmul_pkg::sig_t  sig_y,
    output logic            sign_z,
    output fmul_pkg::fp32_t fp_z
);
    import fmul_pkg::*;

    // Two extra bits hold the sum range and a sign for underflow
    localparam int SW = `FMUL_EXP_W + 2;

    exp_t exp_x;
    exp_t exp_y;
    frc_t frc_x;
    frc_t frc_y;

    // Operand classes, zero includes subnormals (flushed)
    logic x_zero;
    logic x_inf;
    logic x_nan;
    logic y_zero;
    logic y_inf;
    logic y_nan;

    // Result exponent before range checks
    logic signed [SW-1:0] exp_sum;
    exp_t exp_z;
    logic ovf;
    logic udf;

    assign exp_x = fp_x[`FMUL_EXP_W+`FMUL_FRC_W-1:`FMUL_FRC_W];
    assign exp_y = fp_y[`FMUL_EXP_W+`FMUL_FRC_W-1:`FMUL_FRC_W];
    assign frc_x = fp_x[`FMUL_FRC_W-1:0];
    assign frc_y = fp_y[`FMUL_FRC_W-1:0];

    assign x_zero = (exp_x == '0);
    assign y_zero = (exp_y == '0);
    assign x_inf  = (&exp_x) & (frc_x == '0);
    assign y_inf  = (&exp_y) & (frc_y == '0);
    assign x_nan  = (&exp_x) & (frc_x != '0);
    assign y_nan  = (&exp_y) & (frc_y != '0);

    // Hidden bit restored, flushed operands give an all-zero significand
    assign sig_x = x_zero ? '0 : {1'b1, frc_x};
    assign sig_y = y_zero ? '0 : {1'b1, frc_y};

    assign sign_z = fp_x[`FMUL_EXP_W+`FMUL_FRC_W] ^ fp_y[`FMUL_EXP_W+`FMUL_FRC_W];

    // Ex + Ey - bias, plus one per normalization and rounding carry
    assign exp_sum = $signed({2'b00, exp_x} + {2'b00, exp_y} + SW'(norm_n) + SW'(norm_r)
                             - SW'(`FMUL_BIAS));

    // 255 and above would land on the inf/NaN code
    assign ovf   = (exp_sum >= $signed(SW'(255)));
    // Zero and below would need a subnormal, flushed instead
    assign udf   = (exp_sum <= $signed(SW'(0)));
    assign exp_z = exp_sum[`FMUL_EXP_W-1:0];

    // Packing in priority order
    always_comb begin
        if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero)) begin
            fp_z = `FMUL_QNAN;
        end else if (x_inf || y_inf || ovf) begin
            fp_z = {sign_z, {`FMUL_EXP_W{1'b1}}, {`FMUL_FRC_W{1'b0}}};
        end else if (x_zero || y_zero || udf) begin
            fp_z = {sign_z, {(`FMUL_EXP_W+`FMUL_FRC_W){1'b0}}};
        end else begin
            fp_z = {sign_z, exp_z, frc_z};
        end
    end

endmodule

// ==== hw/fmul_norm.sv ====
module fmul_norm (
    input  fmul_pkg::prod_t prod,
    fmul_norm_if.src        nif,
    input  logic            sign_z,
    input  fmul_pkg::rmode_t r_mode
);
    import fmul_pkg::*;

    // Product with its leading one moved to the top bit
    prod_t prod_sh;

    // Product of two values in [1,2) lies in [1,4)
    // Top bit set means the value is 2 or more
    assign nif.norm_n = prod[47];

    // Keep as is when top bit set, else one position left
    assign prod_sh = prod[47] ? prod : {prod[46:0], 1'b0};

    // Hidden bit, 23 fraction bits, guard and round from bits 47 to 22
    // All lower bits fold into sticky
    assign nif.frc_z_norm = {prod_sh[47:22], |prod_sh[21:0]};

    // Sign and mode only pass through to the rounder
    assign nif.sign_z = sign_z;
    assign nif.r_mode = r_mode;

endmodule

// ==== hw/fmul_norm_if.sv ====
interface fmul_norm_if;
    import fmul_pkg::*;

    // Normalized significand with guard, round and sticky
    nsig_t  frc_z_norm;
    // Product top bit was set, exponent gets one more
    logic   norm_n;
    // Context the rounder needs
    logic   sign_z;
    rmode_t r_mode;

    // Normalizer side
    modport src (output frc_z_norm, output norm_n, output sign_z, output r_mode);

    // Rounder side
    modport dst (input frc_z_norm, input norm_n, input sign_z, input r_mode);

endinterface

// ==== hw/fmul_pkg.sv ====
`include "fmul_consts.svh"

package fmul_pkg;

    // Full binary32 word, sign then exponent then fraction
    typedef logic [`FMUL_EXP_W+`FMUL_FRC_W:0] fp32_t;

    // Biased exponent field
    typedef logic [`FMUL_EXP_W-1:0] exp_t;

    // Stored fraction without hidden bit
    typedef logic [`FMUL_FRC_W-1:0] frc_t;

    // Significand with hidden bit on top
    typedef logic [`FMUL_FRC_W:0] sig_t;

    // Full product of two significands
    typedef logic [2*`FMUL_FRC_W+1:0] prod_t;

    // Normalized significand
    // Hidden bit, fraction, then guard, round and sticky
    typedef logic [`FMUL_FRC_W+3:0] nsig_t;

    // Rounding-mode code
    typedef logic [2:0] rmode_t;

    // Wrapper handshake states
    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } fmul_state_e;

endpackage

// ==== hw/fmul_round.sv ====
`include "fmul_consts.svh"

module fmul_round (
    fmul_norm_if.dst        nif,
    output fmul_pkg::frc_t  frc_z,
    output logic            norm_r
);
    import fmul_pkg::*;

    // Truncated fraction and the bits below it
    frc_t frc_trunc;
    logic lsb;
    logic grd;
    logic rnd;
    logic stk;
    logic inexact;
    logic inc;

    // Fraction plus carry into the hidden bit position
    logic [`FMUL_FRC_W:0] frc_sum;

    assign frc_trunc = nif.frc_z_norm[`FMUL_FRC_W+2:3];
    assign lsb       = nif.frc_z_norm[3];
    assign grd       = nif.frc_z_norm[2];
    assign rnd       = nif.frc_z_norm[1];
    assign stk       = nif.frc_z_norm[0];

    // Any discarded bit set
    assign inexact = grd | rnd | stk;

    always_comb begin
        case (nif.r_mode)
            // Plain truncation
            `FMUL_RM_RTZ: inc = 1'b0;
            // Toward minus infinity, grows magnitude of negatives only
            `FMUL_RM_RDN: inc = nif.sign_z & inexact;
            // Toward plus infinity, grows magnitude of positives only
            `FMUL_RM_RUP: inc = ~nif.sign_z & inexact;
            // Ties away from zero
            `FMUL_RM_RMM: inc = grd;
            // Nearest-even, also for the unused codes
            // Exact tie rounds up only from an odd fraction
            default:      inc = grd & (rnd | stk | lsb);
        endcase
    end

    assign frc_sum = {1'b0, frc_trunc} + {{`FMUL_FRC_W{1'b0}}, inc};

    // Carry out of 1.111...1 gives 10.0, fraction wraps to zero
    assign norm_r = frc_sum[`FMUL_FRC_W];
    assign frc_z  = frc_sum[`FMUL_FRC_W-1:0];

endmodule

// ==== hw/fmul_top.sv ====
module fmul_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  fmul_pkg::fp32_t  fp_x,
    input  fmul_pkg::fp32_t  fp_y,
    input  fmul_pkg::rmode_t r_mode,
    output logic             ack,
    output fmul_pkg::fp32_t  fp_z
);
    import fmul_pkg::*;

    fmul_state_e state;
    logic        capture;

    // Operands held for the whole operation
    fp32_t  fp_x_q;
    fp32_t  fp_y_q;
    rmode_t r_mode_q;

    // Datapath nets between the stages
    sig_t  sig_x;
    sig_t  sig_y;
    prod_t prod;
    logic  sign_z;
    frc_t  frc_z;
    logic  norm_r;
    fp32_t fp_z_next;

    fmul_norm_if nif ();

    // New request only accepted while idle
    assign capture = (state == IDLE) && req;

    always_ff @(posedge clk) begin
        if (capture) begin
            fp_x_q   <= fp_x;
            fp_y_q   <= fp_y;
            r_mode_q <= r_mode;
        end
    end

    // Capture edge N, result registered at N+1, ack high at N+2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
            fp_z  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (capture) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    fp_z  <= fp_z_next;
                    state <= DONE;
                end
                DONE: begin
                    // Hold ack and result while the requester keeps req high
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    fmul_booth u_booth (
        .sig_x (sig_x),
        .sig_y (sig_y),
        .prod  (prod)
    );

    fmul_norm u_norm (
        .prod   (prod),
        .nif    (nif),
        .sign_z (sign_z),
        .r_mode (r_mode_q)
    );

    fmul_round u_round (
        .nif    (nif),
        .frc_z  (frc_z),
        .norm_r (norm_r)
    );

    fmul_exp u_exp (
        .fp_x   (fp_x_q),
        .fp_y   (fp_y_q),
        .norm_n (nif.norm_n),
        .norm_r (norm_r),
        .frc_z  (frc_z),
        .sig_x  (sig_x),
        .sig_y  (sig_y),
        .sign_z (sign_z),
        .fp_z   (fp_z_next)
    );

endmodule

// ==== testbench/fmul_checker.sv ====
`include "fmul_consts.svh"

module fmul_checker (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  fmul_pkg::fp32_t  fp_x,
    input  fmul_pkg::fp32_t  fp_y,
    input  fmul_pkg::rmode_t r_mode,
    input  logic             ack,
    input  fmul_pkg::fp32_t  fp_z,
    output logic             err
);
    timeunit 1ns;
    timeprecision 100ps;
    import fmul_pkg::*;

    // Expected binary32 product from exact integer arithmetic
    function automatic fp32_t expected_product(input fp32_t x, input fp32_t y, input rmode_t rm);
        logic        sz;
        logic        x_zero;
        logic        y_zero;
        logic        x_inf;
        logic        y_inf;
        logic        x_nan;
        logic        y_nan;
        logic [47:0] p;
        logic [23:0] kept;
        logic        g;
        logic        rest;
        logic        up;
        logic [24:0] rounded;
        logic [22:0] frac;
        int          ez;
        sz     = x[31] ^ y[31];
        // Exponent field zero covers true zero and flushed subnormals
        x_zero = (x[30:23] == 8'h00);
        y_zero = (y[30:23] == 8'h00);
        x_inf  = (x[30:23] == 8'hff) && (x[22:0] == 23'h0);
        y_inf  = (y[30:23] == 8'hff) && (y[22:0] == 23'h0);
        x_nan  = (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
        y_nan  = (y[30:23] == 8'hff) && (y[22:0] != 23'h0);
        if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero)) begin
            return `FMUL_QNAN;
        end
        if (x_inf || y_inf) begin
            return {sz, 8'hff, 23'h0};
        end
        if (x_zero || y_zero) begin
            return {sz, 31'h0};
        end
        // Exact 48-bit product of the two significands
        p  = {24'h0, 1'b1, x[22:0]} * {24'h0, 1'b1, y[22:0]};
        ez = int'(x[30:23]) + int'(y[30:23]) - `FMUL_BIAS;
        // Value in [2,4) moves the point one place
        if (p[47]) begin
            kept = p[47:24];
            g    = p[23];
            rest = |p[22:0];
            ez   = ez + 1;
        end else begin
            kept = p[46:23];
            g    = p[22];
            rest = |p[21:0];
        end
        case (rm)
            `FMUL_RM_RTZ: up = 1'b0;
            `FMUL_RM_RDN: up = sz && (g || rest);
            `FMUL_RM_RUP: up = !sz && (g || rest);
            `FMUL_RM_RMM: up = g;
            // Nearest-even, ties go to an even fraction
            default:      up = g && (rest || kept[0]);
        endcase
        rounded = {1'b0, kept} + 25'(up);
        // Rounding past 1.111...1 gives 10.0
        if (rounded[24]) begin
            ez   = ez + 1;
            frac = rounded[23:1];
        end else begin
            frac = rounded[22:0];
        end
        if (ez >= 255) begin
            return {sz, 8'hff, 23'h0};
        end
        if (ez <= 0) begin
            return {sz, 31'h0};
        end
        return {sz, ez[7:0], frac};
    endfunction

    // Handshake tracking from the requester's view
    logic  busy;
    logic  cap_ev;
    logic  cap_d1;
    logic  cap_d2;
    logic  ack_m;
    fp32_t exp_q;

    // One flag per assertion
    logic fail_ack = 1'b0;
    logic fail_val = 1'b0;
    logic fail_rst = 1'b0;

    // req seen high with no operation in flight
    assign cap_ev = req && !busy;
    assign err    = fail_ack | fail_val | fail_rst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            cap_d1 <= 1'b0;
            cap_d2 <= 1'b0;
            ack_m  <= 1'b0;
            exp_q  <= '0;
        end else begin
            cap_d1 <= cap_ev;
            cap_d2 <= cap_d1;
            if (cap_ev) begin
                busy  <= 1'b1;
                exp_q <= expected_product(fp_x, fp_y, r_mode);
            end
            // ack up two edges after capture, down one edge after req drops
            if (cap_d2) begin
                ack_m <= 1'b1;
            end else if (ack_m && !req) begin
                ack_m <= 1'b0;
                busy  <= 1'b0;
            end
        end
    end

    a_ack_timing: assert property (@(posedge clk) disable iff (!rst_n) ack == ack_m)
        else begin
            $display("ERR ack expected %h actual %h", $sampled(ack_m), $sampled(ack));
            fail_ack = 1'b1;
        end

    // Result valid and held for as long as ack is high
    a_fp_z_value: assert property (@(posedge clk) disable iff (!rst_n) ack |-> fp_z == exp_q)
        else begin
            $display("ERR fp_z expected %h actual %h", $sampled(exp_q), $sampled(fp_z));
            fail_val = 1'b1;
        end

    // Result register cleared by reset
    a_fp_z_reset: assert property (@(posedge clk) disable iff (!rst_n) $past(!rst_n) |-> fp_z == '0)
        else begin
            $display("ERR fp_z expected %h actual %h", 32'h0, $sampled(fp_z));
            fail_rst = 1'b1;
        end

endmodule

// ==== testbench/tb_fmul.sv ====
module tb_fmul;
    timeunit 1ns;
    timeprecision 100ps;
    import fmul_pkg::*;

    localparam int CLK_NS = 4;
    localparam int DIR_N  = 26;
    localparam int RAND_N = 256;
    // Every directed pair runs under all eight mode codes
    localparam int N_OPS  = DIR_N * 8 + RAND_N;

    // Directed pairs, x in the upper word and y in the lower
    localparam logic [63:0] DIR_OPS [DIR_N] = '{
        64'h3f800000_3f800000, 64'h3fffffff_3fffffff,  // 1*1, max fraction squared
        64'h3fb504f3_3fb504f3, 64'hbfb504f3_3fb504f3,  // rounding carry, both signs
        64'h40490fdb_c02df854, 64'h00000000_3fc00000,  // pi times -e, zero
        64'h80000000_40490fdb, 64'h00400000_c0000000,  // negative zero, subnormal
        64'h3f800000_807fffff, 64'h7f800000_40000000,  // subnormal, inf
        64'hff800000_7f800000, 64'h7f800000_00000000,  // inf times inf, inf times zero
        64'hff800000_00000001, 64'h7fc00000_3f800000,  // inf times subnormal, NaN
        64'h3f800000_ff800001, 64'h7f000000_40000000,  // NaN, sum reaches 255
        64'h7f7fffff_3fffffff, 64'h00800000_3f000000,  // overflow by norm_n, sum 0
        64'h00ffffff_3f000001, 64'h00ffffff_3e800001,  // carry up to 1, carry up to 0
        64'h00c00000_3ec00000, 64'h00c00000_3f400000,  // norm_n up to 0, up to 1
        64'h7f7fffff_3f800000, 64'h7f7fffff_3f800001,  // max finite, carry into 255
        64'h3f3504f3_00b504f3, 64'h7f3504f3_3fb504f3   // norm_r from 0 to 1, 254 to 255
    };

    logic   clk = 1'b0;
    logic   rst_n;
    logic   req;
    fp32_t  fp_x;
    fp32_t  fp_y;
    rmode_t r_mode;
    logic   ack;
    fp32_t  fp_z;
    logic   chk_err;
    logic [31:0] rng;

    always #(CLK_NS / 2) clk = ~clk;

    fmul_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .fp_x   (fp_x),
        .fp_y   (fp_y),
        .r_mode (r_mode),
        .ack    (ack),
        .fp_z   (fp_z)
    );

    fmul_checker u_chk (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .fp_x   (fp_x),
        .fp_y   (fp_y),
        .r_mode (r_mode),
        .ack    (ack),
        .fp_z   (fp_z),
        .err    (chk_err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Exponent field 64..191, products land mostly in range
    function automatic fp32_t normal_operand(input logic [31:0] r);
        return {r[31], 8'd64 + {1'b0, r[30:24]}, r[22:0]};
    endfunction

    // One four-phase transaction, entered just after a rising edge
    task automatic run_op(input fp32_t x, input fp32_t y, input rmode_t rm, input int hold);
        req    = 1'b1;
        fp_x   = x;
        fp_y   = y;
        r_mode = rm;
        do begin
            @(posedge clk);
            #0.5;
        end while (!ack);
        // Back-pressure: keep req high a few more cycles
        repeat (hold) begin
            @(posedge clk);
            #0.5;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #0.5;
        end while (ack);
    endtask

    always @(posedge chk_err) begin
        $display("TB FAILED");
        $fatal(1, "Checker assertion failed");
    end

    initial begin
        #((N_OPS * 12 + 100) * CLK_NS);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired before all operations completed");
    end

    initial begin
        fp32_t a;
        fp32_t b;
        rst_n  = 1'b0;
        req    = 1'b0;
        fp_x   = '0;
        fp_y   = '0;
        r_mode = '0;
        rng    = 32'hb3d2f4c2;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(posedge clk);
        #0.5;
        for (int i = 0; i < DIR_N; i++) begin
            for (int m = 0; m < 8; m++) begin
                rng = xorshift32(rng);
                run_op(DIR_OPS[i][63:32], DIR_OPS[i][31:0], rmode_t'(m), int'(rng[1:0]));
            end
        end
        for (int i = 0; i < RAND_N; i++) begin
            rng = xorshift32(rng);
            a   = normal_operand(rng);
            rng = xorshift32(rng);
            // Now and then a raw word to hit specials and range limits
            b   = (i % 16 == 15) ? rng : normal_operand(rng);
            run_op(a, b, rmode_t'(i % 8), int'(rng[9:8]));
        end
        repeat (2) @(posedge clk);
        #0.5;
        if (chk_err) begin
            $display("TB FAILED");
            $fatal(1, "Checker reported a mismatch");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
